//--- src/csr_pkg.sv
// csr package
// widths, machine CSR addresses, write-target indices, misa value
// and the 64-bit counter view shared across the CSR file
`default_nettype none

package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // machine trap setup and handling
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS    = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISA       = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE        = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC      = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCOUNTEREN = 12'h306;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH   = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC       = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE     = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL      = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP        = 12'h344;

    // counters, low and high halves
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE     = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET   = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH    = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH  = 12'hB82;
    localparam logic [CSR_ADDR_W-1:0] CSR_TIME       = 12'hC01; // read only
    localparam logic [CSR_ADDR_W-1:0] CSR_TIMEH      = 12'hC81; // read only

    // slots in the register array and the write-target vectors
    localparam int MREG_MTVEC      = 0;
    localparam int MREG_MCAUSE     = 1;
    localparam int MREG_MEPC       = 2;
    localparam int MREG_MIE        = 3;
    localparam int MREG_MSTATUS    = 4;
    localparam int MREG_MSCRATCH   = 5;
    localparam int MREG_MIP        = 6;
    localparam int MREG_MTVAL      = 7;
    localparam int MREG_MCOUNTEREN = 8;
    localparam int NUM_MREGS       = 9;

    // counter halves follow the machine registers
    localparam int WT_MCYCLE_LO    = 9;
    localparam int WT_MCYCLE_HI    = 10;
    localparam int WT_MINSTRET_LO  = 11;
    localparam int WT_MINSTRET_HI  = 12;
    localparam int NUM_WR_TARGETS  = 13;

    // address of each write target, highest index first
    localparam logic [NUM_WR_TARGETS-1:0][CSR_ADDR_W-1:0] WT_ADDR = {
        CSR_MINSTRETH, CSR_MINSTRET, CSR_MCYCLEH, CSR_MCYCLE,
        CSR_MCOUNTEREN, CSR_MTVAL, CSR_MIP, CSR_MSCRATCH,
        CSR_MSTATUS, CSR_MIE, CSR_MEPC, CSR_MCAUSE, CSR_MTVEC
    };

    localparam int MSTATUS_MIE_BIT = 3;

    // misa: MXL in the top two bits, one bit per extension letter
    localparam logic [1:0] MISA_MXL   = 2'b01; // 32-bit machine
    localparam logic       MISA_EXT_I = 1'b1;  // bit 8
    localparam logic       MISA_EXT_M = 1'b1;  // bit 12
    localparam logic [XLEN-1:0] MISA_VALUE = {
        MISA_MXL, 4'b0, 13'b0, MISA_EXT_M, 3'b0, MISA_EXT_I, 8'b0
    };

    // one counter word, seen whole for counting or as two csr halves
    typedef union packed {
        logic [2*XLEN-1:0] count;
        struct packed {
            logic [XLEN-1:0] hi;
            logic [XLEN-1:0] lo;
        } halves;
    } counter64_u;

endpackage

`default_nettype wire

//--- src/csr_wr_decode.sv
// csr write decode
// matches both write ports against every writable CSR and yields a
// per-target hit vector plus the targets owned by the execute port
`timescale 1ns/10ps
`default_nettype none

module csr_wr_decode (
    input  logic                                ex_we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]      ex_waddr_i,
    input  logic                                clint_we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]      clint_waddr_i,
    output logic [csr_pkg::NUM_WR_TARGETS-1:0]  wr_hit_o,
    output logic [csr_pkg::NUM_WR_TARGETS-1:0]  wr_from_ex_o
);

    logic [csr_pkg::NUM_WR_TARGETS-1:0] ex_match;    // execute port writes target
    logic [csr_pkg::NUM_WR_TARGETS-1:0] clint_match; // clint port writes target

    always_comb begin
        for (int t = 0; t < csr_pkg::NUM_WR_TARGETS; t++) begin
            ex_match[t]    = ex_we_i && (ex_waddr_i == csr_pkg::WT_ADDR[t]);
            clint_match[t] = clint_we_i && (clint_waddr_i == csr_pkg::WT_ADDR[t]);
        end
    end

    // a target loads when either port hits it
    assign wr_hit_o = ex_match | clint_match;

    // execute wins a shared target, clint data only where execute is absent
    assign wr_from_ex_o = ex_match;

endmodule

`default_nettype wire

//--- src/csr_mregs.sv
// machine register bank
// nine read/write machine CSRs loaded from either write port,
// plus the global interrupt enable taken from mstatus
`timescale 1ns/10ps
`default_nettype none

module csr_mregs (
    input  logic                                            clk,
    input  logic                                            rst_n_i,
    input  logic [csr_pkg::NUM_MREGS-1:0]                   wr_hit_i,
    input  logic [csr_pkg::NUM_MREGS-1:0]                   wr_from_ex_i,
    input  logic [csr_pkg::XLEN-1:0]                        ex_wdata_i,
    input  logic [csr_pkg::XLEN-1:0]                        clint_wdata_i,
    output logic [csr_pkg::NUM_MREGS-1:0][csr_pkg::XLEN-1:0] mreg_q_o,
    output logic                                            global_int_en_o
);

    logic [csr_pkg::NUM_MREGS-1:0][csr_pkg::XLEN-1:0] mreg_d; // per-register write data

    // source select per register
    always_comb begin
        for (int r = 0; r < csr_pkg::NUM_MREGS; r++) begin
            mreg_d[r] = wr_from_ex_i[r] ? ex_wdata_i : clint_wdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mreg_q_o <= '0;
        end else begin
            for (int r = 0; r < csr_pkg::NUM_MREGS; r++) begin
                if (wr_hit_i[r]) begin
                    mreg_q_o[r] <= mreg_d[r]; // untouched registers hold
                end
            end
        end
    end

    // MIE in mstatus gates all machine interrupts
    assign global_int_en_o = mreg_q_o[csr_pkg::MREG_MSTATUS][csr_pkg::MSTATUS_MIE_BIT];

endmodule

`default_nettype wire

//--- src/csr_counters.sv
// csr counters
// mcycle and time count every clock, minstret counts retired
// instructions; mcycle and minstret take 32-bit half writes
`timescale 1ns/10ps
`default_nettype none

module csr_counters (
    input  logic                                                        clk,
    input  logic                                                        rst_n_i,
    input  logic                                                        inst_valid_i,
    input  logic [csr_pkg::NUM_WR_TARGETS-csr_pkg::NUM_MREGS-1:0]       wr_hit_i,
    input  logic [csr_pkg::NUM_WR_TARGETS-csr_pkg::NUM_MREGS-1:0]       wr_from_ex_i,
    input  logic [csr_pkg::XLEN-1:0]                                    ex_wdata_i,
    input  logic [csr_pkg::XLEN-1:0]                                    clint_wdata_i,
    output csr_pkg::counter64_u                                         mcycle_o,
    output csr_pkg::counter64_u                                         minstret_o,
    output csr_pkg::counter64_u                                         time_o
);

    logic [csr_pkg::NUM_WR_TARGETS-csr_pkg::NUM_MREGS-1:0][csr_pkg::XLEN-1:0] half_d;
    csr_pkg::counter64_u mcycle_nxt;
    csr_pkg::counter64_u minstret_nxt;

    // lo write beats hi write, any write beats the increment
    function automatic csr_pkg::counter64_u count_next(
        input csr_pkg::counter64_u       cur,
        input logic                      lo_we,
        input logic                      hi_we,
        input logic [csr_pkg::XLEN-1:0]  lo_d,
        input logic [csr_pkg::XLEN-1:0]  hi_d,
        input logic                      inc
    );
        csr_pkg::counter64_u nxt;
        nxt = cur;
        if (lo_we) begin
            nxt.halves.lo = lo_d;
        end else if (hi_we) begin
            nxt.halves.hi = hi_d;
        end else if (inc) begin
            nxt.count = cur.count + 1'b1;
        end
        return nxt;
    endfunction

    always_comb begin
        for (int h = 0; h < csr_pkg::NUM_WR_TARGETS - csr_pkg::NUM_MREGS; h++) begin
            half_d[h] = wr_from_ex_i[h] ? ex_wdata_i : clint_wdata_i;
        end
        mcycle_nxt = count_next(mcycle_o,
            wr_hit_i[csr_pkg::WT_MCYCLE_LO - csr_pkg::NUM_MREGS],
            wr_hit_i[csr_pkg::WT_MCYCLE_HI - csr_pkg::NUM_MREGS],
            half_d[csr_pkg::WT_MCYCLE_LO - csr_pkg::NUM_MREGS],
            half_d[csr_pkg::WT_MCYCLE_HI - csr_pkg::NUM_MREGS],
            1'b1);
        minstret_nxt = count_next(minstret_o,
            wr_hit_i[csr_pkg::WT_MINSTRET_LO - csr_pkg::NUM_MREGS],
            wr_hit_i[csr_pkg::WT_MINSTRET_HI - csr_pkg::NUM_MREGS],
            half_d[csr_pkg::WT_MINSTRET_LO - csr_pkg::NUM_MREGS],
            half_d[csr_pkg::WT_MINSTRET_HI - csr_pkg::NUM_MREGS],
            inst_valid_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
            time_o     <= '0;
        end else begin
            mcycle_o     <= mcycle_nxt;
            minstret_o   <= minstret_nxt;
            time_o.count <= time_o.count + 1'b1; // free running, no write path
        end
    end

endmodule

`default_nettype wire

//--- src/csr_read_mux.sv
// csr read port
// combinational read of one port with same-port write bypass;
// unmapped addresses return zero
`timescale 1ns/10ps
`default_nettype none

module csr_read_mux (
    input  logic [csr_pkg::CSR_ADDR_W-1:0]                   raddr_i,
    input  logic                                             we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]                   waddr_i,
    input  logic [csr_pkg::XLEN-1:0]                         wdata_i,
    input  logic [csr_pkg::NUM_MREGS-1:0][csr_pkg::XLEN-1:0] mreg_q_i,
    input  csr_pkg::counter64_u                              mcycle_i,
    input  csr_pkg::counter64_u                              minstret_i,
    input  csr_pkg::counter64_u                              time_i,
    output logic [csr_pkg::XLEN-1:0]                         rdata_o
);

    logic                      bypass;  // this port writes what it reads
    logic [csr_pkg::XLEN-1:0]  csr_val; // stored value at raddr_i

    assign bypass = we_i && (waddr_i == raddr_i);

    always_comb begin
        case (raddr_i)
            csr_pkg::CSR_MTVEC:      csr_val = mreg_q_i[csr_pkg::MREG_MTVEC];
            csr_pkg::CSR_MCAUSE:     csr_val = mreg_q_i[csr_pkg::MREG_MCAUSE];
            csr_pkg::CSR_MEPC:       csr_val = mreg_q_i[csr_pkg::MREG_MEPC];
            csr_pkg::CSR_MIE:        csr_val = mreg_q_i[csr_pkg::MREG_MIE];
            csr_pkg::CSR_MSTATUS:    csr_val = mreg_q_i[csr_pkg::MREG_MSTATUS];
            csr_pkg::CSR_MSCRATCH:   csr_val = mreg_q_i[csr_pkg::MREG_MSCRATCH];
            csr_pkg::CSR_MIP:        csr_val = mreg_q_i[csr_pkg::MREG_MIP];
            csr_pkg::CSR_MTVAL:      csr_val = mreg_q_i[csr_pkg::MREG_MTVAL];
            csr_pkg::CSR_MCOUNTEREN: csr_val = mreg_q_i[csr_pkg::MREG_MCOUNTEREN];
            csr_pkg::CSR_MISA:       csr_val = csr_pkg::MISA_VALUE;
            // counter halves
            csr_pkg::CSR_MCYCLE:     csr_val = mcycle_i.halves.lo;
            csr_pkg::CSR_MCYCLEH:    csr_val = mcycle_i.halves.hi;
            csr_pkg::CSR_MINSTRET:   csr_val = minstret_i.halves.lo;
            csr_pkg::CSR_MINSTRETH:  csr_val = minstret_i.halves.hi;
            csr_pkg::CSR_TIME:       csr_val = time_i.halves.lo;
            csr_pkg::CSR_TIMEH:      csr_val = time_i.halves.hi;
            default:                 csr_val = '0; // ids, hpm and holes read zero
        endcase
    end

    // write data shows through in the same cycle
    assign rdata_o = bypass ? wdata_i : csr_val;

endmodule

`default_nettype wire

//--- src/csr.sv
// machine-mode csr file
// two independent ports, one for the execute stage and one for the
// clint; execute wins same-target write conflicts
`timescale 1ns/10ps
`default_nettype none

module csr (
    input  logic                            clk,
    input  logic                            rst_n_i,

    // execute stage
    input  logic                            ex_we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  ex_waddr_i,
    input  logic [csr_pkg::XLEN-1:0]        ex_wdata_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  ex_raddr_i,
    output logic [csr_pkg::XLEN-1:0]        ex_rdata_o,

    // clint
    input  logic                            clint_we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  clint_waddr_i,
    input  logic [csr_pkg::XLEN-1:0]        clint_wdata_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  clint_raddr_i,
    output logic [csr_pkg::XLEN-1:0]        clint_rdata_o,

    input  logic                            inst_valid_i, // one retired instruction
    output logic                            global_int_en_o,
    output logic [csr_pkg::XLEN-1:0]        mtvec_o,
    output logic [csr_pkg::XLEN-1:0]        mepc_o,
    output logic [csr_pkg::XLEN-1:0]        mstatus_o
);

    logic [csr_pkg::NUM_WR_TARGETS-1:0]               wr_hit;
    logic [csr_pkg::NUM_WR_TARGETS-1:0]               wr_from_ex;
    logic [csr_pkg::NUM_MREGS-1:0][csr_pkg::XLEN-1:0] mreg_q;
    csr_pkg::counter64_u                              mcycle_q;
    csr_pkg::counter64_u                              minstret_q;
    csr_pkg::counter64_u                              time_q;

    csr_wr_decode u_wr_decode (
        .ex_we_i       (ex_we_i),
        .ex_waddr_i    (ex_waddr_i),
        .clint_we_i    (clint_we_i),
        .clint_waddr_i (clint_waddr_i),
        .wr_hit_o      (wr_hit),
        .wr_from_ex_o  (wr_from_ex)
    );

    // low slots go to the register bank, the rest to the counters
    csr_mregs u_mregs (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .wr_hit_i        (wr_hit[csr_pkg::NUM_MREGS-1:0]),
        .wr_from_ex_i    (wr_from_ex[csr_pkg::NUM_MREGS-1:0]),
        .ex_wdata_i      (ex_wdata_i),
        .clint_wdata_i   (clint_wdata_i),
        .mreg_q_o        (mreg_q),
        .global_int_en_o (global_int_en_o)
    );

    csr_counters u_counters (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .wr_hit_i      (wr_hit[csr_pkg::NUM_WR_TARGETS-1:csr_pkg::NUM_MREGS]),
        .wr_from_ex_i  (wr_from_ex[csr_pkg::NUM_WR_TARGETS-1:csr_pkg::NUM_MREGS]),
        .ex_wdata_i    (ex_wdata_i),
        .clint_wdata_i (clint_wdata_i),
        .mcycle_o      (mcycle_q),
        .minstret_o    (minstret_q),
        .time_o        (time_q)
    );

    csr_read_mux u_ex_rd (
        .raddr_i    (ex_raddr_i),
        .we_i       (ex_we_i),
        .waddr_i    (ex_waddr_i),
        .wdata_i    (ex_wdata_i),
        .mreg_q_i   (mreg_q),
        .mcycle_i   (mcycle_q),
        .minstret_i (minstret_q),
        .time_i     (time_q),
        .rdata_o    (ex_rdata_o)
    );

    csr_read_mux u_clint_rd (
        .raddr_i    (clint_raddr_i),
        .we_i       (clint_we_i),
        .waddr_i    (clint_waddr_i),
        .wdata_i    (clint_wdata_i),
        .mreg_q_i   (mreg_q),
        .mcycle_i   (mcycle_q),
        .minstret_i (minstret_q),
        .time_i     (time_q),
        .rdata_o    (clint_rdata_o)
    );

    // taps for trap entry and return in the clint
    assign mtvec_o   = mreg_q[csr_pkg::MREG_MTVEC];
    assign mepc_o    = mreg_q[csr_pkg::MREG_MEPC];
    assign mstatus_o = mreg_q[csr_pkg::MREG_MSTATUS];

endmodule

`default_nettype wire

//--- tb/csr_sva.sv
// counter assertions
// stepping rules of mcycle, minstret and time inside csr_counters
`timescale 1ns/10ps
`default_nettype none

module csr_counters_sva (
    input logic                                                  clk,
    input logic                                                  rst_n_i,
    input logic                                                  inst_valid_i,
    input logic [csr_pkg::NUM_WR_TARGETS-csr_pkg::NUM_MREGS-1:0] wr_hit_i,
    input csr_pkg::counter64_u                                   mcycle_o,
    input csr_pkg::counter64_u                                   minstret_o,
    input csr_pkg::counter64_u                                   time_o
);

    int err_cnt = 0; // failed assertion tally

    a_time_step: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) |-> time_o.count == $past(time_o.count) + 64'd1)
    else begin
        err_cnt++;
        $error("time did not advance by one");
    end

    // a half write takes the place of the increment
    a_mcycle_step: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) && !$past(wr_hit_i[csr_pkg::WT_MCYCLE_LO - csr_pkg::NUM_MREGS])
            && !$past(wr_hit_i[csr_pkg::WT_MCYCLE_HI - csr_pkg::NUM_MREGS])
        |-> mcycle_o.count == $past(mcycle_o.count) + 64'd1)
    else begin
        err_cnt++;
        $error("mcycle did not advance by one without a write");
    end

    a_minstret_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) && !$past(inst_valid_i)
            && !$past(wr_hit_i[csr_pkg::WT_MINSTRET_LO - csr_pkg::NUM_MREGS])
            && !$past(wr_hit_i[csr_pkg::WT_MINSTRET_HI - csr_pkg::NUM_MREGS])
        |-> minstret_o.count == $past(minstret_o.count))
    else begin
        err_cnt++;
        $error("minstret changed with no retired instruction");
    end

endmodule

bind csr_counters csr_counters_sva u_sva (.*);

`default_nettype wire

//--- tb/csr_tb.sv
// csr file testbench
// directed and random traffic on both ports, checked every cycle
// against a shadow model of the registers and counters
`timescale 1ns/10ps
`default_nettype none

module csr_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int SEED        = 24323;
    localparam int NUM_RANDOM  = 400;
    localparam int TEST_CYCLES = 5 + 24 + 32 + NUM_RANDOM + 4; // reset, sweep, directed, random
    localparam logic [csr_pkg::XLEN-1:0] MISA_RV32IM = 32'h4000_1100;

    // register slots 0..8 in index order, then misa, counters and dead addresses
    localparam logic [csr_pkg::CSR_ADDR_W-1:0] CSR_LIST [24] = '{
        12'h305, 12'h342, 12'h341, 12'h304, 12'h300, 12'h340, 12'h344, 12'h343, 12'h306,
        12'h301, 12'hB00, 12'hB80, 12'hB02, 12'hB82, 12'hC01, 12'hC81,
        12'h302, 12'h303, 12'hF11, 12'hF12, 12'hF13, 12'hF14, 12'hC03, 12'hB03
    };

    logic                           clk;
    logic                           rst_n_i;
    logic                           ex_we_i;
    logic [csr_pkg::CSR_ADDR_W-1:0] ex_waddr_i;
    logic [csr_pkg::XLEN-1:0]       ex_wdata_i;
    logic [csr_pkg::CSR_ADDR_W-1:0] ex_raddr_i;
    logic [csr_pkg::XLEN-1:0]       ex_rdata_o;
    logic                           clint_we_i;
    logic [csr_pkg::CSR_ADDR_W-1:0] clint_waddr_i;
    logic [csr_pkg::XLEN-1:0]       clint_wdata_i;
    logic [csr_pkg::CSR_ADDR_W-1:0] clint_raddr_i;
    logic [csr_pkg::XLEN-1:0]       clint_rdata_o;
    logic                           inst_valid_i;
    logic                           global_int_en_o;
    logic [csr_pkg::XLEN-1:0]       mtvec_o;
    logic [csr_pkg::XLEN-1:0]       mepc_o;
    logic [csr_pkg::XLEN-1:0]       mstatus_o;

    logic [csr_pkg::XLEN-1:0] m_reg [csr_pkg::NUM_MREGS]; // shadow machine registers
    logic [63:0]              m_mcycle;
    logic [63:0]              m_minstret;
    logic [63:0]              m_time;
    int                       n_checks = 0;
    int                       n_errors = 0;
    int                       n_sva    = 0;

    csr dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_word(input string name, input logic [csr_pkg::XLEN-1:0] exp,
                              input logic [csr_pkg::XLEN-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // data landing on one address at this edge, execute port first
    function automatic logic [csr_pkg::XLEN:0] write_to(
        input logic [csr_pkg::CSR_ADDR_W-1:0] addr
    );
        if (ex_we_i && ex_waddr_i == addr) begin
            return {1'b1, ex_wdata_i};
        end
        if (clint_we_i && clint_waddr_i == addr) begin
            return {1'b1, clint_wdata_i};
        end
        return '0;
    endfunction

    function automatic logic [63:0] step_counter(input logic [63:0] cur,
        input logic [csr_pkg::XLEN:0] lo, input logic [csr_pkg::XLEN:0] hi, input logic inc);
        if (lo[csr_pkg::XLEN]) begin
            return {cur[63:32], lo[31:0]}; // lo wins over hi
        end
        if (hi[csr_pkg::XLEN]) begin
            return {hi[31:0], cur[31:0]};
        end
        return cur + 64'(inc);
    endfunction

    task automatic update_model();
        logic [csr_pkg::XLEN:0] w;
        if (!rst_n_i) begin
            m_reg      = '{default: '0};
            m_mcycle   = '0;
            m_minstret = '0;
            m_time     = '0;
            return;
        end
        for (int r = 0; r < csr_pkg::NUM_MREGS; r++) begin
            w = write_to(CSR_LIST[r]);
            if (w[csr_pkg::XLEN]) begin
                m_reg[r] = w[csr_pkg::XLEN-1:0];
            end
        end
        m_mcycle   = step_counter(m_mcycle, write_to(12'hB00), write_to(12'hB80), 1'b1);
        m_minstret = step_counter(m_minstret, write_to(12'hB02), write_to(12'hB82), inst_valid_i);
        m_time     = m_time + 64'd1;
    endtask

    // expected read data of one port
    function automatic logic [csr_pkg::XLEN-1:0] ref_read(
        input logic [csr_pkg::CSR_ADDR_W-1:0] raddr,
        input logic                           we,
        input logic [csr_pkg::CSR_ADDR_W-1:0] waddr,
        input logic [csr_pkg::XLEN-1:0]       wdata
    );
        logic [csr_pkg::XLEN-1:0] val;
        val = '0;
        for (int r = 0; r < csr_pkg::NUM_MREGS; r++) begin
            if (raddr == CSR_LIST[r]) begin
                val = m_reg[r];
            end
        end
        case (raddr)
            12'h301: val = MISA_RV32IM;
            12'hB00: val = m_mcycle[31:0];
            12'hB80: val = m_mcycle[63:32];
            12'hB02: val = m_minstret[31:0];
            12'hB82: val = m_minstret[63:32];
            12'hC01: val = m_time[31:0];
            12'hC81: val = m_time[63:32];
            default: ;
        endcase
        if (we && waddr == raddr) begin
            val = wdata; // same-port bypass
        end
        return val;
    endfunction

    task automatic drive_cycle(
        input logic                           exw,
        input logic [csr_pkg::CSR_ADDR_W-1:0] exa,
        input logic [csr_pkg::XLEN-1:0]       exd,
        input logic [csr_pkg::CSR_ADDR_W-1:0] exr,
        input logic                           clw,
        input logic [csr_pkg::CSR_ADDR_W-1:0] cla,
        input logic [csr_pkg::XLEN-1:0]       cld,
        input logic [csr_pkg::CSR_ADDR_W-1:0] clr,
        input logic                           iv
    );
        @(negedge clk);
        ex_we_i       = exw;
        ex_waddr_i    = exa;
        ex_wdata_i    = exd;
        ex_raddr_i    = exr;
        clint_we_i    = clw;
        clint_waddr_i = cla;
        clint_wdata_i = cld;
        clint_raddr_i = clr;
        inst_valid_i  = iv;
    endtask

    task automatic read_both(input logic [csr_pkg::CSR_ADDR_W-1:0] exr,
                             input logic [csr_pkg::CSR_ADDR_W-1:0] clr);
        drive_cycle(1'b0, '0, '0, exr, 1'b0, '0, '0, clr, 1'b0);
    endtask

    initial begin : compare
        forever begin
            @(posedge clk);
            update_model();
            @(negedge clk);
            #(CLK_PERIOD / 2 - 1); // just ahead of the next rising edge
            check_word("ex_rdata_o", ref_read(ex_raddr_i, ex_we_i, ex_waddr_i, ex_wdata_i),
                       ex_rdata_o);
            check_word("clint_rdata_o",
                       ref_read(clint_raddr_i, clint_we_i, clint_waddr_i, clint_wdata_i),
                       clint_rdata_o);
            check_bit("global_int_en_o", m_reg[4][3], global_int_en_o);
            check_word("mtvec_o", m_reg[0], mtvec_o);
            check_word("mepc_o", m_reg[2], mepc_o);
            check_word("mstatus_o", m_reg[4], mstatus_o);
        end
    end

    initial begin : watchdog
        #(TEST_CYCLES * CLK_PERIOD * 2);
        $display("timeout: run still going after %0d clock cycles", TEST_CYCLES * 2);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(SEED));
        rst_n_i = 1'b0;
        ex_we_i = 1'b0;
        ex_waddr_i = '0;
        ex_wdata_i = '0;
        ex_raddr_i = '0;
        clint_we_i = 1'b0;
        clint_waddr_i = '0;
        clint_wdata_i = '0;
        clint_raddr_i = '0;
        inst_valid_i = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        foreach (CSR_LIST[i]) begin
            read_both(CSR_LIST[i], CSR_LIST[i]);
        end
        // same target from both ports, then two different targets
        drive_cycle(1'b1, csr_pkg::CSR_MSCRATCH, 32'hA5A5_0001, csr_pkg::CSR_MSCRATCH,
                    1'b1, csr_pkg::CSR_MSCRATCH, 32'h5A5A_0002, csr_pkg::CSR_MSCRATCH, 1'b0);
        read_both(csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MSCRATCH);
        drive_cycle(1'b1, csr_pkg::CSR_MEPC, 32'h1000_0040, csr_pkg::CSR_MTVEC,
                    1'b1, csr_pkg::CSR_MTVEC, 32'h8000_0100, csr_pkg::CSR_MEPC, 1'b0);
        read_both(csr_pkg::CSR_MEPC, csr_pkg::CSR_MTVEC);
        // writer sees its own data, other port the old value
        drive_cycle(1'b1, csr_pkg::CSR_MCAUSE, 32'h8000_0007, csr_pkg::CSR_MCAUSE,
                    1'b0, '0, '0, csr_pkg::CSR_MCAUSE, 1'b0);
        drive_cycle(1'b0, '0, '0, csr_pkg::CSR_MIE,
                    1'b1, csr_pkg::CSR_MIE, 32'h0000_0888, csr_pkg::CSR_MIE, 1'b0);
        read_both(csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MIE);
        drive_cycle(1'b1, csr_pkg::CSR_MSTATUS, 32'h0000_0008, '0, 1'b0, '0, '0, '0, 1'b0);
        read_both(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MSTATUS);
        drive_cycle(1'b0, '0, '0, '0, 1'b1, csr_pkg::CSR_MSTATUS, 32'h0000_1880, '0, 1'b0);
        read_both(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MSTATUS);
        // lo close to wrap so the carry reaches the high half
        drive_cycle(1'b1, csr_pkg::CSR_MCYCLE, 32'hFFFF_FFFD, csr_pkg::CSR_MCYCLE,
                    1'b0, '0, '0, csr_pkg::CSR_MCYCLEH, 1'b1);
        repeat (4) read_both(csr_pkg::CSR_MCYCLE, csr_pkg::CSR_MCYCLEH);
        drive_cycle(1'b0, '0, '0, csr_pkg::CSR_MCYCLE,
                    1'b1, csr_pkg::CSR_MCYCLEH, 32'h0000_0123, csr_pkg::CSR_MCYCLEH, 1'b0);
        drive_cycle(1'b1, csr_pkg::CSR_MINSTRET, 32'h0000_0007, csr_pkg::CSR_MINSTRET,
                    1'b1, csr_pkg::CSR_MINSTRETH, 32'h0000_0055, csr_pkg::CSR_MINSTRETH, 1'b1);
        for (int i = 0; i < 6; i++) begin
            drive_cycle(1'b0, '0, '0, csr_pkg::CSR_MINSTRET,
                        1'b0, '0, '0, csr_pkg::CSR_TIME, 1'(i % 2));
        end
        drive_cycle(1'b0, '0, '0, csr_pkg::CSR_MINSTRETH,
                    1'b1, csr_pkg::CSR_MINSTRETH, 32'h0000_ABCD, csr_pkg::CSR_TIMEH, 1'b1);
        drive_cycle(1'b1, csr_pkg::CSR_TIME, 32'h1234_5678, csr_pkg::CSR_MISA,
                    1'b1, csr_pkg::CSR_MISA, 32'h0, csr_pkg::CSR_TIME, 1'b0);
        read_both(csr_pkg::CSR_TIME, csr_pkg::CSR_MISA);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            drive_cycle(1'($urandom_range(1)), CSR_LIST[$urandom_range(23)], $urandom(),
                        CSR_LIST[$urandom_range(23)], 1'($urandom_range(1)),
                        CSR_LIST[$urandom_range(23)], $urandom(),
                        CSR_LIST[$urandom_range(23)], 1'($urandom_range(1)));
        end
        read_both('0, '0);
        repeat (2) @(posedge clk);
        n_sva = dut.u_counters.u_sva.err_cnt;
        $display("checks: %0d  value errors: %0d  assertion failures: %0d",
                 n_checks, n_errors, n_sva);
        if (n_errors == 0 && n_sva == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/csr_pkg.sv
src/csr_wr_decode.sv
src/csr_mregs.sv
src/csr_counters.sv
src/csr_read_mux.sv
src/csr.sv
tb/csr_sva.sv
tb/csr_tb.sv
